//--- logic/ex_pkg.sv
// Opcodes, command, decoded-operation and write-back types, latency constants
package ex_pkg;

  ////////////////////
  // Constants
  ////////////////////

  // Multiplier iterations, one byte of operand b per step
  localparam int unsigned MULT_STEPS = 4;
  // High-unsigned multiply support
  localparam bit MULH_EN = 1'b1;

  ////////////////////
  // Opcodes
  ////////////////////

  typedef enum logic [3:0] {
    OP_ADD   = 4'h0,
    OP_SUB   = 4'h1,
    OP_AND   = 4'h2,
    OP_OR    = 4'h3,
    OP_XOR   = 4'h4,
    OP_SLL   = 4'h5,
    OP_SRL   = 4'h6,
    OP_SRA   = 4'h7,
    OP_SLT   = 4'h8,
    OP_SLTU  = 4'h9,
    OP_MUL   = 4'hA,
    OP_MULHU = 4'hB,
    OP_BEQ   = 4'hC,
    OP_BNE   = 4'hD,
    OP_BLT   = 4'hE,
    OP_BGEU  = 4'hF
  } ex_op_e;

  // Execution unit select
  typedef enum logic {
    UNIT_ALU  = 1'b0,
    UNIT_MULT = 1'b1
  } ex_unit_e;

  ////////////////////
  // Records
  ////////////////////

  // Incoming command, 105 bits
  typedef struct packed {
    ex_op_e      op;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    // Branch target for branch opcodes
    logic [31:0] operand_c;
    logic [4:0]  rd;
  } ex_cmd_t;

  // Decoded operation held in the decode register
  typedef struct packed {
    ex_unit_e    unit;
    ex_op_e      alu_func;
    logic        mult_high;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [31:0] operand_c;
    logic [4:0]  rd;
    logic        we;
    logic        is_branch;
    logic        illegal;
  } ex_dec_t;

  // Write-back record
  typedef struct packed {
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        is_branch;
    logic        taken;
    logic [31:0] target;
    logic        illegal;
  } ex_wb_t;

endpackage

//--- logic/ex_pipe_slice.sv
// One-entry valid/ready register slice with a type-parameter payload
`timescale 1ns/1ps

module ex_pipe_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  // Upstream side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  // Downstream side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     full_q;
  payload_t data_q;

  // Accept when empty or when the held entry leaves this cycle
  assign in_ready_o = ~full_q | out_ready_i;

  // Occupancy flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (in_ready_o) begin
      full_q <= in_valid_i;
    end
  end

  // Payload register, only loaded on a transfer in
  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  ////////////////////
  // Assertions
  ////////////////////

  // Stalled entry stays valid and unchanged
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o))
  );

endmodule

//--- logic/ex_decoder.sv
// Combinational command decoder, unit select, ALU function and write-back flags
`timescale 1ns/1ps

module ex_decoder (
  input  ex_pkg::ex_cmd_t cmd_i,
  output ex_pkg::ex_dec_t dec_o
);

  always_comb begin
    // Defaults for a plain ALU operation
    dec_o           = '0;
    dec_o.unit      = ex_pkg::UNIT_ALU;
    dec_o.alu_func  = cmd_i.op;
    dec_o.operand_a = cmd_i.operand_a;
    dec_o.operand_b = cmd_i.operand_b;
    dec_o.operand_c = cmd_i.operand_c;
    dec_o.rd        = cmd_i.rd;
    dec_o.we        = 1'b1;

    case (cmd_i.op)
      // Low half of the product
      ex_pkg::OP_MUL: begin
        dec_o.unit = ex_pkg::UNIT_MULT;
      end

      // High half, only when the multiplier supports it
      ex_pkg::OP_MULHU: begin
        if (ex_pkg::MULH_EN) begin
          dec_o.unit      = ex_pkg::UNIT_MULT;
          dec_o.mult_high = 1'b1;
        end else begin
          // Flagged and retired through the ALU path with no write
          dec_o.we      = 1'b0;
          dec_o.illegal = 1'b1;
        end
      end

      // Branches never write the register file
      ex_pkg::OP_BEQ,
      ex_pkg::OP_BNE,
      ex_pkg::OP_BLT,
      ex_pkg::OP_BGEU: begin
        dec_o.we        = 1'b0;
        dec_o.is_branch = 1'b1;
      end

      // Arithmetic, logic, shift and compare
      default: begin
        dec_o.unit = ex_pkg::UNIT_ALU;
      end
    endcase
  end

endmodule

//--- logic/ex_alu.sv
// Single-cycle ALU with arithmetic, logic, shift, set-less-than and branch compare
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::ex_op_e func_i,
  input  logic [31:0]    operand_a_i,
  input  logic [31:0]    operand_b_i,
  output logic [31:0]    result_o,
  output logic           cmp_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  // Shift amount from the low five bits of b
  assign shamt = operand_b_i[4:0];

  // Shared comparators
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;
  assign equal       = operand_a_i == operand_b_i;

  ////////////////////
  // Result
  ////////////////////

  always_comb begin
    case (func_i)
      ex_pkg::OP_ADD:  result_o = operand_a_i + operand_b_i;
      ex_pkg::OP_SUB:  result_o = operand_a_i - operand_b_i;
      ex_pkg::OP_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::OP_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::OP_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::OP_SLL:  result_o = operand_a_i << shamt;
      ex_pkg::OP_SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      ex_pkg::OP_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      ex_pkg::OP_SLT:  result_o = {31'd0, lt_signed};
      ex_pkg::OP_SLTU: result_o = {31'd0, lt_unsigned};
      // Multiplies and branches produce no ALU data
      default:         result_o = '0;
    endcase
  end

  ////////////////////
  // Branch decision
  ////////////////////

  always_comb begin
    case (func_i)
      ex_pkg::OP_BEQ:  cmp_o = equal;
      ex_pkg::OP_BNE:  cmp_o = ~equal;
      ex_pkg::OP_BLT:  cmp_o = lt_signed;
      ex_pkg::OP_BGEU: cmp_o = ~lt_unsigned;
      default:         cmp_o = 1'b0;
    endcase
  end

endmodule

//--- logic/ex_mult.sv
// Iterative radix-256 shift-add 32x32 multiplier with start/done handshake
`timescale 1ns/1ps

module ex_mult (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  logic        high_i,
  input  logic [31:0] operand_a_i,
  input  logic [31:0] operand_b_i,
  output logic        busy_o,
  output logic        done_o,
  output logic [31:0] result_o
);

  localparam int unsigned STEP_W = $clog2(ex_pkg::MULT_STEPS);

  logic              busy_q;
  logic              done_q;
  logic [STEP_W-1:0] step_q;
  logic              last_step;

  // Datapath registers
  logic [63:0] mcand_q;
  logic [31:0] mplier_q;
  logic [63:0] acc_q;
  logic        high_q;

  assign last_step = (step_q == STEP_W'(ex_pkg::MULT_STEPS - 1));

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else begin
      // Done is a single-cycle pulse after the final step
      done_q <= busy_q & last_step;
      if (start_i) begin
        busy_q <= 1'b1;
        step_q <= '0;
      end else if (busy_q) begin
        busy_q <= ~last_step;
        step_q <= step_q + STEP_W'(1);
      end
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge clk) begin
    if (start_i) begin
      mcand_q  <= {32'd0, operand_a_i};
      mplier_q <= operand_b_i;
      acc_q    <= '0;
      high_q   <= high_i;
    end else if (busy_q) begin
      // One byte of b per step, a moves up a byte each time
      acc_q    <= acc_q + mcand_q * {56'd0, mplier_q[7:0]};
      mcand_q  <= mcand_q << 8;
      mplier_q <= mplier_q >> 8;
    end
  end

  assign busy_o   = busy_q;
  assign done_o   = done_q;
  assign result_o = high_q ? acc_q[63:32] : acc_q[31:0];

  ////////////////////
  // Assertions
  ////////////////////

  // No new operation while one is running
  a_no_restart: assert property (
    @(posedge clk) disable iff (!rst_n) start_i |-> !busy_o
  );

  // Fixed latency from start to the done pulse
  a_latency: assert property (
    @(posedge clk) disable iff (!rst_n) start_i |-> ##(ex_pkg::MULT_STEPS + 1) done_o
  );

endmodule

//--- logic/ex_execute.sv
// Execute stage that steers decoded operations to the ALU or the multiplier
`timescale 1ns/1ps

module ex_execute (
  input  logic            clk,
  input  logic            rst_n,
  // From the decode register
  input  logic            dec_valid_i,
  output logic            dec_ready_o,
  input  ex_pkg::ex_dec_t dec_i,
  // Raw result towards the result stage
  output logic            raw_valid_o,
  input  logic            raw_ready_i,
  output ex_pkg::ex_wb_t  raw_o
);

  logic [31:0]    alu_result;
  logic           alu_cmp;
  logic [31:0]    mult_result;
  logic           mult_busy;
  logic           mult_done;
  logic           mult_start;
  logic           mult_active;
  logic           is_mult;
  logic           hold_valid_q;
  ex_pkg::ex_wb_t hold_q;
  ex_pkg::ex_wb_t pend_q;
  ex_pkg::ex_wb_t alu_rec;
  ex_pkg::ex_wb_t mult_rec;

  ex_alu u_alu (
    .func_i      (dec_i.alu_func),
    .operand_a_i (dec_i.operand_a),
    .operand_b_i (dec_i.operand_b),
    .result_o    (alu_result),
    .cmp_o       (alu_cmp)
  );

  ex_mult u_mult (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (mult_start),
    .high_i      (dec_i.mult_high),
    .operand_a_i (dec_i.operand_a),
    .operand_b_i (dec_i.operand_b),
    .busy_o      (mult_busy),
    .done_o      (mult_done),
    .result_o    (mult_result)
  );

  ////////////////////
  // Steering
  ////////////////////

  assign is_mult = (dec_i.unit == ex_pkg::UNIT_MULT);
  // A multiply owns the stage from start until its result leaves
  assign mult_active = mult_busy | mult_done | hold_valid_q;
  assign mult_start  = dec_valid_i & is_mult & ~mult_active;
  // A multiply is taken at once, ALU ops only when the result stage takes them
  assign dec_ready_o = ~mult_active & (is_mult | raw_ready_i);
  assign raw_valid_o = mult_active ? (mult_done | hold_valid_q) : (dec_valid_i & ~is_mult);

  // ALU and illegal record
  always_comb begin
    alu_rec           = '0;
    alu_rec.we        = dec_i.we;
    alu_rec.waddr     = dec_i.rd;
    alu_rec.wdata     = dec_i.we ? alu_result : '0;
    alu_rec.is_branch = dec_i.is_branch;
    alu_rec.taken     = dec_i.is_branch & alu_cmp;
    alu_rec.target    = dec_i.is_branch ? dec_i.operand_c : '0;
    alu_rec.illegal   = dec_i.illegal;
  end

  // Multiply record, flags from the start plus the product
  always_comb begin
    mult_rec       = pend_q;
    mult_rec.wdata = mult_result;
  end

  assign raw_o = hold_valid_q ? hold_q : (mult_done ? mult_rec : alu_rec);

  ////////////////////
  // Multiply bookkeeping
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid_q <= 1'b0;
    end else if (mult_done) begin
      hold_valid_q <= ~raw_ready_i;
    end else if (raw_ready_i) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mult_start) begin
      pend_q       <= '0;
      pend_q.we    <= dec_i.we;
      pend_q.waddr <= dec_i.rd;
    end
    // Park the product if the result stage is stalled
    if (mult_done) begin
      hold_q <= mult_rec;
    end
  end

  // Offered result stays put until taken
  a_raw_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (raw_valid_o && !raw_ready_i) |=> (raw_valid_o && $stable(raw_o))
  );

endmodule

//--- logic/ex_result.sv
// Result stage with register-0 write suppression and write-back register
`timescale 1ns/1ps

module ex_result (
  input  logic           clk,
  input  logic           rst_n,
  // Raw record from execute
  input  logic           raw_valid_i,
  output logic           raw_ready_o,
  input  ex_pkg::ex_wb_t raw_i,
  // Write-back output
  output logic           wb_valid_o,
  input  logic           wb_ready_i,
  output ex_pkg::ex_wb_t wb_o
);

  ex_pkg::ex_wb_t wb_clean;

  ////////////////////
  // Register 0 filter
  ////////////////////

  always_comb begin
    wb_clean = raw_i;
    // x0 is hardwired to zero
    if (raw_i.waddr == 5'd0) begin
      wb_clean.we    = 1'b0;
      wb_clean.wdata = '0;
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  ex_pipe_slice #(
    .payload_t (ex_pkg::ex_wb_t)
  ) u_wb_slice (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (raw_valid_i),
    .in_ready_o  (raw_ready_o),
    .in_data_i   (wb_clean),
    .out_valid_o (wb_valid_o),
    .out_ready_i (wb_ready_i),
    .out_data_o  (wb_o)
  );

endmodule

//--- logic/ex_unit_top.sv
// Execute subsystem top, decoder, decode register, execute and result stages
`timescale 1ns/1ps

module ex_unit_top (
  input  logic            clk,
  input  logic            rst_n,
  // Command input
  input  logic            cmd_valid_i,
  output logic            cmd_ready_o,
  input  ex_pkg::ex_cmd_t cmd_i,
  // Write-back output
  output logic            wb_valid_o,
  input  logic            wb_ready_i,
  output ex_pkg::ex_wb_t  wb_o
);

  ex_pkg::ex_dec_t dec_comb;
  ex_pkg::ex_dec_t dec_q;
  logic            dec_valid;
  logic            dec_ready;
  ex_pkg::ex_wb_t  raw;
  logic            raw_valid;
  logic            raw_ready;

  ex_decoder u_decoder (
    .cmd_i (cmd_i),
    .dec_o (dec_comb)
  );

  // Decode register
  ex_pipe_slice #(
    .payload_t (ex_pkg::ex_dec_t)
  ) u_dec_slice (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (cmd_valid_i),
    .in_ready_o  (cmd_ready_o),
    .in_data_i   (dec_comb),
    .out_valid_o (dec_valid),
    .out_ready_i (dec_ready),
    .out_data_o  (dec_q)
  );

  ex_execute u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec_valid_i (dec_valid),
    .dec_ready_o (dec_ready),
    .dec_i       (dec_q),
    .raw_valid_o (raw_valid),
    .raw_ready_i (raw_ready),
    .raw_o       (raw)
  );

  ex_result u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .raw_valid_i (raw_valid),
    .raw_ready_o (raw_ready),
    .raw_i       (raw),
    .wb_valid_o  (wb_valid_o),
    .wb_ready_i  (wb_ready_i),
    .wb_o        (wb_o)
  );

endmodule

//--- include/ex_tb_model.svh
// Reference model function giving the expected write-back record of a command
`ifndef EX_TB_MODEL_SVH
`define EX_TB_MODEL_SVH

function automatic ex_pkg::ex_wb_t ex_tb_model(input ex_pkg::ex_cmd_t cmd);
  ex_pkg::ex_wb_t wb;
  logic [63:0]    prod;
  logic [4:0]     sh;
  logic [31:0]    a;
  logic [31:0]    b;
  logic           lt_s;
  a        = cmd.operand_a;
  b        = cmd.operand_b;
  sh       = b[4:0];
  prod     = {32'd0, a} * {32'd0, b};
  // Signed order, differing signs decide, otherwise the unsigned order
  lt_s     = (a[31] != b[31]) ? a[31] : (a < b);
  wb       = '0;
  wb.we    = 1'b1;
  wb.waddr = cmd.rd;
  case (cmd.op)
    ex_pkg::OP_ADD:  wb.wdata = a + b;
    ex_pkg::OP_SUB:  wb.wdata = a - b;
    ex_pkg::OP_AND:  wb.wdata = a & b;
    ex_pkg::OP_OR:   wb.wdata = a | b;
    ex_pkg::OP_XOR:  wb.wdata = a ^ b;
    ex_pkg::OP_SLL:  wb.wdata = a << sh;
    ex_pkg::OP_SRL:  wb.wdata = a >> sh;
    // Top sh bits filled with copies of the sign bit
    ex_pkg::OP_SRA:  wb.wdata = (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
    ex_pkg::OP_SLT:  wb.wdata = {31'd0, lt_s};
    ex_pkg::OP_SLTU: wb.wdata = {31'd0, a < b};
    ex_pkg::OP_MUL:  wb.wdata = prod[31:0];
    ex_pkg::OP_MULHU: begin
      if (ex_pkg::MULH_EN) begin
        wb.wdata = prod[63:32];
      end else begin
        wb.we      = 1'b0;
        wb.illegal = 1'b1;
      end
    end
    default: begin
      // Branch compares
      wb.we        = 1'b0;
      wb.is_branch = 1'b1;
      wb.target    = cmd.operand_c;
      case (cmd.op)
        ex_pkg::OP_BEQ: wb.taken = (a == b);
        ex_pkg::OP_BNE: wb.taken = (a != b);
        ex_pkg::OP_BLT: wb.taken = lt_s;
        default:        wb.taken = (a >= b);
      endcase
    end
  endcase
  // x0 writes dropped
  if (cmd.rd == 5'd0) begin
    wb.we    = 1'b0;
    wb.wdata = '0;
  end
  return wb;
endfunction

`endif

//--- verification/tb_ex_unit.sv
// Testbench for the execute subsystem with LCG stimulus, model queue, checks and timeout
`timescale 1ns/1ps

module tb_ex_unit;

  localparam int NUM_CMDS  = 400;
  localparam int TIMEOUT   = NUM_CMDS * (int'(ex_pkg::MULT_STEPS) + 4) + 100;
  localparam int RESET_CYC = 4;

  // DUT inputs start at known values
  logic            clk         = 1'b0;
  logic            rst_n       = 1'b0;
  logic            cmd_valid_i = 1'b0;
  ex_pkg::ex_cmd_t cmd_i       = '0;
  logic            wb_ready_i  = 1'b0;
  logic            cmd_ready_o;
  logic            wb_valid_o;
  ex_pkg::ex_wb_t  wb_o;

  // Expected records in command order
  ex_pkg::ex_wb_t  exp_q[$];
  logic [31:0]     lcg_state  = 32'd63370;
  int              errors     = 0;
  int              accepted   = 0;
  int              received   = 0;
  int              cycles     = 0;
  logic            run_en     = 1'b0;
  // Output side as seen at the previous edge
  logic            last_valid = 1'b0;
  logic            last_ready = 1'b0;
  ex_pkg::ex_wb_t  last_wb    = '0;

  `include "ex_tb_model.svh"

  ex_unit_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .wb_valid_o  (wb_valid_o),
    .wb_ready_i  (wb_ready_i),
    .wb_o        (wb_o)
  );

  // 100 ns period
  always #50 clk = ~clk;

  ////////////////////
  // Random stimulus
  ////////////////////

  // Upper half of the state, the low bits of an LCG repeat too quickly
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic logic [31:0] rand_word();
    logic [15:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
  endfunction

  function automatic ex_pkg::ex_cmd_t random_cmd();
    ex_pkg::ex_cmd_t c;
    logic [15:0]     r;
    r           = lcg_next();
    c.op        = ex_pkg::ex_op_e'(r[3:0]);
    // About one command in eight targets x0
    c.rd        = (r[6:4] == 3'd0) ? 5'd0 : r[11:7];
    c.operand_a = rand_word();
    c.operand_b = rand_word();
    c.operand_c = rand_word();
    // Equal operands now and then, so BEQ and BGEU see both outcomes
    if (r[14:12] == 3'd0) begin
      c.operand_b = c.operand_a;
    end
    return c;
  endfunction

  ////////////////////
  // Checking helpers
  ////////////////////

  task automatic check_field(input int idx, input string name,
                             input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED cmd %0d %s got %h expected %h", idx, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_record(input ex_pkg::ex_wb_t got, input ex_pkg::ex_wb_t exp,
                                input int idx);
    check_field(idx, "wb_o.we", 32'(got.we), 32'(exp.we));
    check_field(idx, "wb_o.waddr", 32'(got.waddr), 32'(exp.waddr));
    check_field(idx, "wb_o.wdata", got.wdata, exp.wdata);
    check_field(idx, "wb_o.is_branch", 32'(got.is_branch), 32'(exp.is_branch));
    check_field(idx, "wb_o.taken", 32'(got.taken), 32'(exp.taken));
    check_field(idx, "wb_o.target", got.target, exp.target);
    check_field(idx, "wb_o.illegal", 32'(got.illegal), 32'(exp.illegal));
  endtask

  task automatic report_and_finish();
    $display("Run done: %0d commands sent, %0d records received, %0d errors",
             accepted, received, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  ////////////////////
  // Drive and monitor
  ////////////////////

  // Values read here are those before the edge, new inputs go out as NBAs
  always @(posedge clk) begin
    logic [15:0] r;
    logic        hold;
    if (rst_n) begin
      // Stalled record must stay offered and unchanged
      if (last_valid && !last_ready) begin
        assert (wb_valid_o === 1'b1) else begin
          $display("CHECK FAILED wb_valid_o got %h expected %h", wb_valid_o, 1'b1);
          errors++;
        end
        assert (wb_o === last_wb) else begin
          $display("CHECK FAILED wb_o got %h expected %h", wb_o, last_wb);
          errors++;
        end
      end
      // Output transfer pops the oldest expected record
      if (wb_valid_o && wb_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("A write-back record arrived with no command outstanding");
          errors++;
        end else begin
          compare_record(wb_o, exp_q.pop_front(), received);
        end
        received++;
      end
      last_valid = wb_valid_o;
      last_ready = wb_ready_i;
      last_wb    = wb_o;
    end
    if (run_en) begin
      r    = lcg_next();
      hold = cmd_valid_i & ~cmd_ready_o;
      // Input transfer, remember what the model says
      if (cmd_valid_i && cmd_ready_o) begin
        exp_q.push_back(ex_tb_model(cmd_i));
        accepted++;
      end
      // Ready high in 11 of 16 cycles
      wb_ready_i <= (r[3:0] < 4'd11);
      // Offered command stays until taken
      if (!hold) begin
        if (accepted < NUM_CMDS && r[7:5] != 3'd0) begin
          cmd_valid_i <= 1'b1;
          cmd_i       <= random_cmd();
        end else begin
          cmd_valid_i <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    repeat (RESET_CYC) @(posedge clk);
    rst_n <= 1'b1;
    // Idle after reset, nothing may come out
    repeat (3) begin
      @(posedge clk);
      assert (wb_valid_o === 1'b0) else begin
        $display("CHECK FAILED wb_valid_o got %h expected %h", wb_valid_o, 1'b0);
        errors++;
      end
    end
    run_en <= 1'b1;
    wait (received == NUM_CMDS);
    // Drain time to catch stray records
    repeat (4 * int'(ex_pkg::MULT_STEPS)) @(posedge clk);
    assert (received == NUM_CMDS && exp_q.size() == 0) else begin
      $display("Record count is off, %0d received and %0d still expected",
               received, exp_q.size());
      errors++;
    end
    report_and_finish();
  end

  // Cycle limit sized from the run length
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, only %0d of %0d records received",
               cycles, received, NUM_CMDS);
      errors++;
      report_and_finish();
    end
  end

endmodule

//--- compile.f
+incdir+include
logic/ex_pkg.sv
logic/ex_pipe_slice.sv
logic/ex_decoder.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_execute.sv
logic/ex_result.sv
logic/ex_unit_top.sv
verification/tb_ex_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_ex_unit \
  -o tb_ex_unit > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_ex_unit > sim.log 2>&1 \
  || { echo "Simulation exited abnormally, see sim.log"; exit 1; }

grep -qx "No errors" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
